// File: verilog/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

	////////////////////////////////////////
	// scan codes and key events
	////////////////////////////////////////

	typedef logic [7:0] scan_code_t; // one byte as sent by the keyboard

	typedef struct packed {
		scan_code_t code; // make or break code without its prefixes
		logic       extended; // an E0 prefix came first
		logic       is_break; // an F0 prefix came first
	} key_event_t;

	localparam scan_code_t SCAN_BREAK_PREFIX = 8'hF0; // key release follows
	localparam scan_code_t SCAN_EXT_PREFIX   = 8'hE0; // extended key set follows

	////////////////////////////////////////
	// display
	////////////////////////////////////////

	// bit order a,b,c,d,e,f,g,dp from the MSB down, a segment lights on 0
	typedef logic [7:0] seg_t;

endpackage

`default_nettype wire

// File: verilog/ps2_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_rx import ps2_pkg::*; #(
	parameter int FILTER_LEN = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output scan_code_t rx_code,
	output logic       rx_valid,
	input  logic       rx_ready,
	output logic       parity_error,
	output logic       overflow
);

	localparam int CNT_W = $clog2(FILTER_LEN) + 1;

	logic [1:0]       clk_sync;
	logic [1:0]       data_sync;
	logic             clk_s;
	logic             data_s;
	logic             clk_filt; // debounced copy of the ps2 clock
	logic [CNT_W-1:0] flt_cnt;
	logic             clk_fall;
	logic [3:0]       bit_cnt;
	logic [9:0]       shift;
	logic [10:0]      frame_next;
	logic             frame_end;
	logic             frame_ok;
	logic             load_code;

	////////////////////////////////////////
	// synchronizer and glitch filter
	////////////////////////////////////////

	assign clk_s  = clk_sync[1];
	assign data_s = data_sync[1];

	always_ff @(posedge clk) begin
		if (rst) begin
			clk_sync  <= 2'b11; // both lines idle high
			data_sync <= 2'b11;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
		end
	end

	// a new clock level is taken only after FILTER_LEN cycles without a change
	always_ff @(posedge clk) begin
		if (rst) begin
			clk_filt <= 1'b1;
			flt_cnt  <= '0;
		end else if (clk_s == clk_filt) begin
			flt_cnt <= '0; // a glitch shorter than the filter starts over
		end else if (flt_cnt == CNT_W'(FILTER_LEN - 1)) begin
			clk_filt <= clk_s;
			flt_cnt  <= '0;
		end else begin
			flt_cnt <= flt_cnt + 1'b1;
		end
	end

	assign clk_fall = clk_filt && !clk_s && (flt_cnt == CNT_W'(FILTER_LEN - 1));

	////////////////////////////////////////
	// frame shifter
	////////////////////////////////////////

	// bits arrive LSB first, so the frame fills from the top
	assign frame_next = {data_s, shift};
	assign frame_end  = clk_fall && (bit_cnt == 4'd10);

	// start low, stop high, and odd parity over data plus parity bit
	assign frame_ok = !frame_next[0] && frame_next[10] && (^frame_next[9:1]);

	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt <= '0;
		end else if (clk_fall) begin
			bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (clk_fall) begin
			shift <= frame_next[10:1];
		end
	end

	////////////////////////////////////////
	// code output and error flags
	////////////////////////////////////////

	// the line cannot wait, so a code that finds the output still full is lost
	assign load_code = frame_end && frame_ok && !(rx_valid && !rx_ready);

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_valid     <= 1'b0;
			parity_error <= 1'b0;
			overflow     <= 1'b0;
		end else begin
			if (rx_valid && rx_ready) begin
				rx_valid <= 1'b0;
			end
			if (frame_end && !frame_ok) begin
				parity_error <= 1'b1; // also covers a bad start or stop bit
			end
			if (frame_end && frame_ok && rx_valid && !rx_ready) begin
				overflow <= 1'b1;
			end
			if (load_code) begin
				rx_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_code) begin
			rx_code <= frame_next[8:1];
		end
	end

	// the counter wraps after the stop bit and never runs into a 12th bit
	bit_cnt_range: assert property (@(posedge clk) disable iff (rst) bit_cnt <= 4'd10);

endmodule

`default_nettype wire

// File: verilog/scan_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module scan_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  FIFO_DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	localparam int AW = $clog2(FIFO_DEPTH);

	payload_t mem [FIFO_DEPTH];
	logic [AW:0] wr_ptr; // top bit flips on every wrap
	logic [AW:0] rd_ptr;
	logic [AW:0] fill;
	logic        push;
	logic        pop;

	assign fill = wr_ptr - rd_ptr;

	assign in_ready  = (fill != (AW + 1)'(FIFO_DEPTH));
	assign out_valid = (fill != '0);

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	// the head is read straight from memory, so a push shows one cycle later
	assign out_data = mem[rd_ptr[AW-1:0]];

	////////////////////////////////////////
	// pointers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr[AW-1:0]] <= in_data;
		end
	end

	// an overrun or an underrun would push the fill level past the depth
	fill_bound: assert property (@(posedge clk) disable iff (rst)
		fill <= (AW + 1)'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: verilog/key_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module key_tracker import ps2_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  scan_code_t code_data,
	input  logic       code_valid,
	output logic       code_ready,
	output key_event_t event_data,
	output logic       event_valid,
	input  logic       event_ready,
	output scan_code_t last_make,
	output logic       have_make,
	output logic [7:0] release_count
);

	logic break_pending; // F0 seen, waiting for the code it belongs to
	logic ext_pending;   // E0 seen, same
	logic accept;
	logic is_break_prefix;
	logic is_ext_prefix;
	logic new_event;

	// a held event blocks input unless it leaves in this very cycle
	assign code_ready = !event_valid || event_ready;
	assign accept     = code_valid && code_ready;

	assign is_break_prefix = (code_data == SCAN_BREAK_PREFIX);
	assign is_ext_prefix   = (code_data == SCAN_EXT_PREFIX);
	assign new_event       = accept && !is_break_prefix && !is_ext_prefix;

	////////////////////////////////////////
	// prefix state and event register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			event_valid   <= 1'b0;
			break_pending <= 1'b0;
			ext_pending   <= 1'b0;
		end else begin
			if (event_valid && event_ready) begin
				event_valid <= 1'b0;
			end
			if (accept && is_break_prefix) begin
				break_pending <= 1'b1; // prefixes are swallowed without output
			end
			if (accept && is_ext_prefix) begin
				ext_pending <= 1'b1;
			end
			if (new_event) begin
				event_valid   <= 1'b1;
				break_pending <= 1'b0;
				ext_pending   <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (new_event) begin
			event_data.code     <= code_data;
			event_data.extended <= ext_pending;
			event_data.is_break <= break_pending;
		end
	end

	////////////////////////////////////////
	// key statistics for the display
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			have_make     <= 1'b0;
			release_count <= '0;
		end else if (new_event) begin
			if (break_pending) begin
				release_count <= release_count + 8'd1; // wraps at 256
			end else begin
				have_make <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (new_event && !break_pending) begin
			last_make <= code_data; // auto-repeat makes land here too
		end
	end

	// a stalled event must not change or disappear until it is taken
	event_hold: assert property (@(posedge clk) disable iff (rst)
		event_valid && !event_ready |=> event_valid && $stable(event_data));

endmodule

`default_nettype wire

// File: verilog/seg_display.sv
`timescale 1ns/1ps
`default_nettype none

module seg_display import ps2_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  scan_code_t last_make,
	input  logic       have_make,
	input  logic [7:0] release_count,
	output seg_t       seg0,
	output seg_t       seg1,
	output seg_t       seg4,
	output seg_t       seg5
);

	localparam seg_t SEG_BLANK = 8'hFF; // every segment dark

	////////////////////////////////////////
	// hex digit table
	////////////////////////////////////////

	function automatic seg_t hex_digit(input logic [3:0] nib);
		case (nib)
			4'h0:    return 8'b0000_0011;
			4'h1:    return 8'b1001_1111;
			4'h2:    return 8'b0010_0101;
			4'h3:    return 8'b0000_1101;
			4'h4:    return 8'b1001_1001;
			4'h5:    return 8'b0100_1001;
			4'h6:    return 8'b0100_0001;
			4'h7:    return 8'b0001_1111;
			4'h8:    return 8'b0000_0001;
			4'h9:    return 8'b0000_1001;
			4'hA:    return 8'b0001_0001;
			4'hB:    return 8'b1100_0001; // lower case b so it differs from 8
			4'hC:    return 8'b0110_0011;
			4'hD:    return 8'b1000_0101; // lower case d so it differs from 0
			4'hE:    return 8'b0110_0001;
			default: return 8'b0111_0001;
		endcase
	endfunction

	////////////////////////////////////////
	// output registers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			seg0 <= SEG_BLANK; // nothing pressed yet
			seg1 <= SEG_BLANK;
			seg4 <= hex_digit(4'h0);
			seg5 <= hex_digit(4'h0);
		end else begin
			seg0 <= have_make ? hex_digit(last_make[3:0]) : SEG_BLANK;
			seg1 <= have_make ? hex_digit(last_make[7:4]) : SEG_BLANK;
			seg4 <= hex_digit(release_count[3:0]);
			seg5 <= hex_digit(release_count[7:4]);
		end
	end

endmodule

`default_nettype wire

// File: verilog/kbd_top.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_top import ps2_pkg::*; #(
	parameter int FILTER_LEN = 4,
	parameter int FIFO_DEPTH = 4 // must be a power of two
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output key_event_t event_data,
	output logic       event_valid,
	input  logic       event_ready,
	output logic       parity_error,
	output logic       overflow,
	output seg_t       seg0,
	output seg_t       seg1,
	output seg_t       seg4,
	output seg_t       seg5
);

	scan_code_t rx_code;
	logic       rx_valid;
	logic       rx_ready;
	scan_code_t code_data;
	logic       code_valid;
	logic       code_ready;
	scan_code_t last_make;
	logic       have_make;
	logic [7:0] release_count;

	////////////////////////////////////////
	// receive chain
	////////////////////////////////////////

	ps2_rx #(
		.FILTER_LEN (FILTER_LEN)
	) u_rx (
		.clk          (clk),
		.rst          (rst),
		.ps2_clk      (ps2_clk),
		.ps2_data     (ps2_data),
		.rx_code      (rx_code),
		.rx_valid     (rx_valid),
		.rx_ready     (rx_ready),
		.parity_error (parity_error),
		.overflow     (overflow)
	);

	scan_fifo #(
		.payload_t  (scan_code_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk       (clk),
		.rst       (rst),
		.in_data   (rx_code),
		.in_valid  (rx_valid),
		.in_ready  (rx_ready),
		.out_data  (code_data),
		.out_valid (code_valid),
		.out_ready (code_ready)
	);

	key_tracker u_tracker (
		.clk           (clk),
		.rst           (rst),
		.code_data     (code_data),
		.code_valid    (code_valid),
		.code_ready    (code_ready),
		.event_data    (event_data),
		.event_valid   (event_valid),
		.event_ready   (event_ready),
		.last_make     (last_make),
		.have_make     (have_make),
		.release_count (release_count)
	);

	seg_display u_display (
		.clk           (clk),
		.rst           (rst),
		.last_make     (last_make),
		.have_make     (have_make),
		.release_count (release_count),
		.seg0          (seg0),
		.seg1          (seg1),
		.seg4          (seg4),
		.seg5          (seg5)
	);

endmodule

`default_nettype wire

// File: tb/tb_kbd_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_kbd_top import ps2_pkg::*; ();

	localparam int FILTER_LEN    = 4;
	localparam int FIFO_DEPTH    = 4;
	localparam int HALF_BIT      = 10; // clk cycles per ps2_clk phase
	localparam int EVENT_TIMEOUT = 400; // clk cycles, well above one frame's latency
	localparam int QUIET_TIME    = 50;

	logic        clk;
	logic        rst;
	logic        ps2_clk;
	logic        ps2_data;
	key_event_t  event_data;
	logic        event_valid;
	logic        event_ready;
	logic        parity_error;
	logic        overflow;
	seg_t        seg0;
	seg_t        seg1;
	seg_t        seg4;
	seg_t        seg5;
	int unsigned seed_value;
	logic [7:0]  release_total; // expected release counter
	scan_code_t  last_code;     // expected last make code
	key_event_t  taken [$];     // events handed over at the output, oldest first

	kbd_top #(
		.FILTER_LEN (FILTER_LEN),
		.FIFO_DEPTH (FIFO_DEPTH)
	) dut0 (
		.clk          (clk),
		.rst          (rst),
		.ps2_clk      (ps2_clk),
		.ps2_data     (ps2_data),
		.event_data   (event_data),
		.event_valid  (event_valid),
		.event_ready  (event_ready),
		.parity_error (parity_error),
		.overflow     (overflow),
		.seg0         (seg0),
		.seg1         (seg1),
		.seg4         (seg4),
		.seg5         (seg5)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// an event lasts one cycle when event_ready is high, so every transfer is recorded
	always @(posedge clk) begin
		if (!rst && event_valid && event_ready) begin
			taken.push_back(event_data);
		end
	end

	////////////////////////////////////////
	// checking helpers
	////////////////////////////////////////

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, msg,
				actual, expected);
			$display("Simulation failed");
			$fatal(1, "stopping at the first error");
		end
	endtask

	task automatic stop_run(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	// active-low pattern built from the names of the lit segments
	function automatic seg_t seg_pattern(input logic [3:0] nib);
		string lit;
		seg_t  pat;
		case (nib)
			4'h0:    lit = "abcdef";
			4'h1:    lit = "bc";
			4'h2:    lit = "abdeg";
			4'h3:    lit = "abcdg";
			4'h4:    lit = "bcfg";
			4'h5:    lit = "acdfg";
			4'h6:    lit = "acdefg";
			4'h7:    lit = "abc";
			4'h8:    lit = "abcdefg";
			4'h9:    lit = "abcdfg";
			4'hA:    lit = "abcefg";
			4'hB:    lit = "cdefg"; // lower case b
			4'hC:    lit = "adef";
			4'hD:    lit = "bcdeg"; // lower case d
			4'hE:    lit = "adefg";
			default: lit = "aefg";
		endcase
		pat = 8'hFF;
		for (int i = 0; i < lit.len(); i++) begin
			pat[7 - (lit[i] - "a")] = 1'b0; // segment a sits in the MSB
		end
		return pat;
	endfunction

	task automatic check_segments(input scan_code_t make, input logic [7:0] count);
		repeat (3) @(negedge clk); // the display lags the tracker by one register
		check(seg0, seg_pattern(make[3:0]), "seg0 shows the low digit of the last make");
		check(seg1, seg_pattern(make[7:4]), "seg1 shows the high digit of the last make");
		check(seg4, seg_pattern(count[3:0]), "seg4 shows the low digit of the releases");
		check(seg5, seg_pattern(count[7:4]), "seg5 shows the high digit of the releases");
	endtask

	task automatic check_event(input key_event_t ev, input scan_code_t code,
			input logic ext, input logic brk);
		check(ev.code, code, "event code");
		check(ev.extended, ext, "event extended flag");
		check(ev.is_break, brk, "event break flag");
	endtask

	////////////////////////////////////////
	// stimulus and waiting
	////////////////////////////////////////

	task automatic apply_reset();
		rst = 1'b1;
		repeat (4) @(posedge clk); // four rising edges see reset high
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
	endtask

	// keyboard side of one frame: start, eight data bits LSB first, parity, stop
	task automatic send_frame(input scan_code_t code, input logic bad_parity);
		logic [10:0] frame;
		frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			repeat (HALF_BIT / 2) @(negedge clk);
			ps2_data = frame[i]; // changes in the middle of the high phase
			repeat (HALF_BIT / 2) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (HALF_BIT) @(negedge clk);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
		repeat (HALF_BIT) @(negedge clk);
	endtask

	// called on a falling edge, hands back the oldest event taken at the output
	task automatic wait_event(output key_event_t ev);
		for (int n = 0; n < EVENT_TIMEOUT; n++) begin
			if (taken.size() != 0) begin
				ev = taken.pop_front();
				return;
			end
			@(negedge clk);
		end
		stop_run("timed out waiting for a key event");
	endtask

	task automatic expect_no_event(input int cycles);
		for (int n = 0; n < cycles; n++) begin
			if (event_valid || taken.size() != 0) begin
				stop_run("a key event appeared where none was expected");
			end
			@(negedge clk);
		end
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic test_reset_state();
		check(event_valid, 1'b0, "event_valid low after reset");
		check(parity_error, 1'b0, "parity_error low after reset");
		check(overflow, 1'b0, "overflow low after reset");
		check(seg0, 8'hFF, "seg0 blank after reset");
		check(seg1, 8'hFF, "seg1 blank after reset");
		check(seg4, seg_pattern(4'h0), "seg4 shows 0 after reset");
		check(seg5, seg_pattern(4'h0), "seg5 shows 0 after reset");
	endtask

	task automatic test_make();
		scan_code_t code;
		key_event_t ev;
		code = scan_code_t'($urandom);
		if (code == SCAN_BREAK_PREFIX || code == SCAN_EXT_PREFIX) begin
			code = code ^ 8'h01;
		end
		send_frame(code, 1'b0);
		wait_event(ev);
		check_event(ev, code, 1'b0, 1'b0);
		expect_no_event(QUIET_TIME);
		last_code = code;
		check_segments(last_code, release_total);
	endtask

	task automatic test_release();
		key_event_t ev;
		send_frame(SCAN_BREAK_PREFIX, 1'b0);
		expect_no_event(QUIET_TIME); // the prefix alone makes no event
		send_frame(last_code, 1'b0);
		wait_event(ev);
		check_event(ev, last_code, 1'b0, 1'b1);
		release_total++;
		expect_no_event(QUIET_TIME);
		check_segments(last_code, release_total);
	endtask

	task automatic test_extended();
		key_event_t ev;
		send_frame(SCAN_EXT_PREFIX, 1'b0);
		send_frame(SCAN_BREAK_PREFIX, 1'b0);
		send_frame(8'h6B, 1'b0);
		wait_event(ev);
		check_event(ev, 8'h6B, 1'b1, 1'b1);
		release_total++;
		send_frame(SCAN_EXT_PREFIX, 1'b0);
		send_frame(8'h74, 1'b0);
		wait_event(ev);
		check_event(ev, 8'h74, 1'b1, 1'b0);
		last_code = 8'h74;
		check_segments(last_code, release_total);
	endtask

	task automatic test_parity_error();
		key_event_t ev;
		send_frame(8'h1C, 1'b1);
		expect_no_event(EVENT_TIMEOUT);
		check(parity_error, 1'b1, "parity_error set by a bad frame");
		send_frame(8'h1B, 1'b0);
		wait_event(ev);
		check_event(ev, 8'h1B, 1'b0, 1'b0);
		last_code = 8'h1B;
		check_segments(last_code, release_total);
	endtask

	task automatic test_overflow();
		key_event_t ev;
		event_ready = 1'b0;
		for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
			if (i == FIFO_DEPTH + 2) begin
				check(overflow, 1'b0, "no overflow while the chain still has room");
			end
			send_frame(scan_code_t'(8'h15 + i), 1'b0);
		end
		check(overflow, 1'b1, "overflow set by a frame the chain cannot hold");
		event_ready = 1'b1;
		for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
			wait_event(ev);
			check_event(ev, scan_code_t'(8'h15 + i), 1'b0, 1'b0);
		end
		expect_no_event(EVENT_TIMEOUT); // the dropped frame never shows up
		last_code = scan_code_t'(8'h15 + FIFO_DEPTH + 1);
		check_segments(last_code, release_total);
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		seed_value    = $urandom(59);
		rst           = 1'b1;
		ps2_clk       = 1'b1; // bus idles high
		ps2_data      = 1'b1;
		event_ready   = 1'b1;
		release_total = 8'd0;
		last_code     = 8'h00;
		apply_reset();
		test_reset_state();
		test_make();
		test_release();
		test_extended();
		test_parity_error();
		test_overflow();
		apply_reset();
		release_total = 8'd0;
		test_reset_state();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
verilog/ps2_pkg.sv
verilog/ps2_rx.sv
verilog/scan_fifo.sv
verilog/key_tracker.sv
verilog/seg_display.sv
verilog/kbd_top.sv
tb/tb_kbd_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_kbd_top
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
